// ==== src/core_types_pkg.sv ====
// core sizing constants
// physical register file, register banks and the load completion queue
`default_nettype none

package core_types_pkg;

    // physical registers, banked on the low tag bits
    localparam int PR_COUNT = 32;
    localparam int LOG_PR_COUNT = $clog2(PR_COUNT);
    localparam int PRF_BANK_COUNT = 2;
    localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);

    // load completion queue
    localparam int LDU_CQ_ENTRIES = 8;
    localparam int LOG_LDU_CQ_ENTRIES = $clog2(LDU_CQ_ENTRIES);

    localparam int DATA_W = 32;

endpackage

`default_nettype wire

// ==== src/ldu_pkg.sv ====
// load op encodings and access size decoding
`default_nettype none

package ldu_pkg;

    localparam int LDU_OP_W = 4;
    localparam int LDU_IMM_W = 12;

    // low two bits of an op hold log2 of the access size
    localparam logic [LDU_OP_W-1:0] LDU_LB  = 4'b0000;
    localparam logic [LDU_OP_W-1:0] LDU_LH  = 4'b0001;
    localparam logic [LDU_OP_W-1:0] LDU_LW  = 4'b0010;
    localparam logic [LDU_OP_W-1:0] LDU_LBU = 4'b0100;
    localparam logic [LDU_OP_W-1:0] LDU_LHU = 4'b0101;

    // size field values
    localparam logic [1:0] LDU_SIZE_B = 2'd0;
    localparam logic [1:0] LDU_SIZE_H = 2'd1;
    localparam logic [1:0] LDU_SIZE_W = 2'd2;

endpackage

`default_nettype wire

// ==== src/wb_bus_if.sv ====
// banked writeback bus, one write strobe per register bank
`timescale 1ns/1ps
`default_nettype none

interface wb_bus_if;
    import core_types_pkg::*;

    logic [PRF_BANK_COUNT-1:0]                                      valid;
    // tag bits above the bank select
    logic [PRF_BANK_COUNT-1:0][LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr;
    logic [PRF_BANK_COUNT-1:0][DATA_W-1:0]                          data;

    modport writer (
        output valid, upper_pr, data
    );

    modport listener (
        input valid, upper_pr, data
    );

endinterface

`default_nettype wire

// ==== src/ldu_issue_if.sv ====
// issued load from the issue queue to the address stage
`timescale 1ns/1ps
`default_nettype none

interface ldu_issue_if;
    import core_types_pkg::*;
    import ldu_pkg::*;

    logic                           valid;
    logic [LDU_OP_W-1:0]            op;
    logic [LDU_IMM_W-1:0]           imm12;
    logic                           a_forward;
    logic                           a_is_zero;
    logic [LOG_PRF_BANK_COUNT-1:0]  a_bank;
    logic [LOG_LDU_CQ_ENTRIES-1:0]  cq_index;
    // address stage can take a load this cycle
    logic                           pipeline_ready;

    modport queue (
        output valid, op, imm12, a_forward, a_is_zero, a_bank, cq_index,
        input  pipeline_ready
    );

    modport stage (
        input  valid, op, imm12, a_forward, a_is_zero, a_bank, cq_index,
        output pipeline_ready
    );

endinterface

`default_nettype wire

// ==== src/pe_lsb.sv ====
// lowest-set-bit priority encoder with a one-hot grant and a grant-and-above mask
`timescale 1ns/1ps
`default_nettype none

module pe_lsb #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] req_vec,
    output logic [WIDTH-1:0] ack_one_hot,
    output logic [WIDTH-1:0] ack_mask
);

    always_comb begin : scan
        logic found;
        found = 1'b0;
        // mask turns on at the first request and stays on above it
        for (int i = 0; i < WIDTH; i++) begin
            ack_one_hot[i] = req_vec[i] & ~found;
            found = found | req_vec[i];
            ack_mask[i] = found;
        end
    end

endmodule

`default_nettype wire

// ==== src/ldu_iq.sv ====
// collapsing load issue queue
// writeback wakeup, oldest-ready select and enqueue into the lowest free slot
`timescale 1ns/1ps
`default_nettype none

module ldu_iq #(
    parameter int LDU_IQ_ENTRIES = 4
) (
    input  logic CLK,
    input  logic nRST,

    // enqueue from dispatch
    input  logic                                            enq_valid,
    input  logic [ldu_pkg::LDU_OP_W-1:0]                    enq_op,
    input  logic [ldu_pkg::LDU_IMM_W-1:0]                   enq_imm12,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0]         enq_a_pr,
    input  logic                                            enq_a_ready,
    input  logic                                            enq_a_is_zero,
    input  logic [core_types_pkg::LOG_LDU_CQ_ENTRIES-1:0]   enq_cq_index,
    output logic                                            enq_ready,

    wb_bus_if.listener  wb,
    ldu_issue_if.queue  iss,

    // operand read request to the register file
    output logic                                    prf_req_valid,
    output logic [core_types_pkg::LOG_PR_COUNT-1:0] prf_req_pr
);
    import core_types_pkg::*;
    import ldu_pkg::*;

    localparam int TOP = LDU_IQ_ENTRIES - 1;

    // entry state, entry 0 is the oldest
    logic [LDU_IQ_ENTRIES-1:0]                          valid_by_entry;
    logic [LDU_IQ_ENTRIES-1:0]                          a_ready_by_entry;
    logic [LDU_IQ_ENTRIES-1:0][LDU_OP_W-1:0]            op_by_entry;
    logic [LDU_IQ_ENTRIES-1:0][LDU_IMM_W-1:0]           imm12_by_entry;
    logic [LDU_IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0]        a_pr_by_entry;
    logic [LDU_IQ_ENTRIES-1:0]                          a_is_zero_by_entry;
    logic [LDU_IQ_ENTRIES-1:0][LOG_LDU_CQ_ENTRIES-1:0]  cq_index_by_entry;

    logic [LDU_IQ_ENTRIES-1:0]  a_forward_by_entry;
    logic [LDU_IQ_ENTRIES-1:0]  issue_req;
    logic [LDU_IQ_ENTRIES-1:0]  issue_one_hot;
    logic [LDU_IQ_ENTRIES-1:0]  issue_mask;
    logic [LDU_IQ_ENTRIES-1:0]  free_by_entry;
    logic [LDU_IQ_ENTRIES-1:0]  free_one_hot;
    logic [LDU_IQ_ENTRIES:0]    valid_ext;
    logic [LDU_IQ_ENTRIES:0]    enq_ext;
    logic [LDU_IQ_ENTRIES-1:0]  src_valid;
    logic [LDU_IQ_ENTRIES-1:0]  src_enq;
    logic                       enq_a_ready_eff;

    // slot that moves down into entry i on a collapse
    function automatic int up_of(input int i);
        return (i < TOP) ? i + 1 : i;
    endfunction

    // tag is on the writeback bus of its bank this cycle
    function automatic logic wb_hit(input logic [LOG_PR_COUNT-1:0] pr);
        logic [LOG_PRF_BANK_COUNT-1:0] bank;
        bank = pr[LOG_PRF_BANK_COUNT-1:0];
        return wb.valid[bank]
            && (wb.upper_pr[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
    endfunction

    // ----------------------------------------------------------
    // wakeup and issue

    always_comb begin
        for (int i = 0; i < LDU_IQ_ENTRIES; i++) begin
            a_forward_by_entry[i] = wb_hit(a_pr_by_entry[i]);
        end
    end

    // a load enqueued during its operand's writeback is already awake
    assign enq_a_ready_eff = enq_a_ready | wb_hit(enq_a_pr);

    assign issue_req = {LDU_IQ_ENTRIES{iss.pipeline_ready}} & valid_by_entry
        & (a_ready_by_entry | a_forward_by_entry | a_is_zero_by_entry);

    pe_lsb #(.WIDTH(LDU_IQ_ENTRIES)) issue_pe (
        .req_vec     (issue_req),
        .ack_one_hot (issue_one_hot),
        .ack_mask    (issue_mask)
    );

    // one-hot mux of the selected entry
    always_comb begin
        iss.valid = |issue_req;
        iss.op = '0;
        iss.imm12 = '0;
        iss.a_forward = 1'b0;
        iss.a_is_zero = 1'b0;
        iss.a_bank = '0;
        iss.cq_index = '0;
        prf_req_valid = 1'b0;
        prf_req_pr = '0;
        for (int i = 0; i < LDU_IQ_ENTRIES; i++) begin
            if (issue_one_hot[i]) begin
                iss.op |= op_by_entry[i];
                iss.imm12 |= imm12_by_entry[i];
                iss.a_forward |= a_forward_by_entry[i];
                iss.a_is_zero |= a_is_zero_by_entry[i];
                iss.a_bank |= a_pr_by_entry[i][LOG_PRF_BANK_COUNT-1:0];
                iss.cq_index |= cq_index_by_entry[i];
                // only a plain register operand needs the read port
                prf_req_valid |= ~a_forward_by_entry[i] & ~a_is_zero_by_entry[i];
                prf_req_pr |= a_pr_by_entry[i];
            end
        end
    end

    // ----------------------------------------------------------
    // enqueue and collapse

    assign free_by_entry = ~valid_by_entry;
    assign enq_ready = |free_by_entry;

    pe_lsb #(.WIDTH(LDU_IQ_ENTRIES)) free_pe (
        .req_vec     (free_by_entry),
        .ack_one_hot (free_one_hot),
        .ack_mask    ()
    );

    assign valid_ext = {1'b0, valid_by_entry};
    assign enq_ext = {1'b0, free_one_hot & {LDU_IQ_ENTRIES{enq_valid}}};

    // at and above the issued slot each entry takes the one above it
    always_comb begin
        for (int i = 0; i < LDU_IQ_ENTRIES; i++) begin
            src_valid[i] = issue_mask[i] ? valid_ext[i+1] : valid_ext[i];
            src_enq[i] = issue_mask[i] ? enq_ext[i+1] : enq_ext[i];
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_by_entry <= '0;
            a_ready_by_entry <= '0;
        end else begin
            for (int i = 0; i < LDU_IQ_ENTRIES; i++) begin
                valid_by_entry[i] <= src_valid[i] | src_enq[i];
                if (!src_valid[i]) begin
                    a_ready_by_entry[i] <= enq_a_ready_eff;
                end else if (issue_mask[i]) begin
                    a_ready_by_entry[i] <= a_ready_by_entry[up_of(i)]
                        | a_forward_by_entry[up_of(i)];
                end else begin
                    a_ready_by_entry[i] <= a_ready_by_entry[i] | a_forward_by_entry[i];
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < LDU_IQ_ENTRIES; i++) begin
            if (!src_valid[i]) begin
                op_by_entry[i] <= enq_op;
                imm12_by_entry[i] <= enq_imm12;
                a_pr_by_entry[i] <= enq_a_pr;
                a_is_zero_by_entry[i] <= enq_a_is_zero;
                cq_index_by_entry[i] <= enq_cq_index;
            end else if (issue_mask[i]) begin
                op_by_entry[i] <= op_by_entry[up_of(i)];
                imm12_by_entry[i] <= imm12_by_entry[up_of(i)];
                a_pr_by_entry[i] <= a_pr_by_entry[up_of(i)];
                a_is_zero_by_entry[i] <= a_is_zero_by_entry[up_of(i)];
                cq_index_by_entry[i] <= cq_index_by_entry[up_of(i)];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/prf_banked.sv ====
// banked physical register file
// one writeback port per bank, one combinational read port
`timescale 1ns/1ps
`default_nettype none

module prf_banked (
    input  logic CLK,
    input  logic nRST,

    wb_bus_if.listener wb,

    input  logic                                    rd_valid,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0] rd_pr,
    output logic [core_types_pkg::DATA_W-1:0]       rd_data
);
    import core_types_pkg::*;

    localparam int BANK_DEPTH = PR_COUNT / PRF_BANK_COUNT;

    logic [PRF_BANK_COUNT-1:0][BANK_DEPTH-1:0][DATA_W-1:0] regs;

    // registers come out of reset as zero
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            regs <= '0;
        end else begin
            for (int b = 0; b < PRF_BANK_COUNT; b++) begin
                if (wb.valid[b]) begin
                    regs[b][wb.upper_pr[b]] <= wb.data[b];
                end
            end
        end
    end

    // bank from the low tag bits, row from the rest
    assign rd_data = rd_valid
        ? regs[rd_pr[LOG_PRF_BANK_COUNT-1:0]][rd_pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]]
        : '0;

endmodule

`default_nettype wire

// ==== src/ldu_agen.sv ====
// load address generation
// base operand select, immediate add, misalign check and output register
`timescale 1ns/1ps
`default_nettype none

module ldu_agen (
    input  logic CLK,
    input  logic nRST,

    ldu_issue_if.stage  iss,
    wb_bus_if.listener  wb,

    input  logic [core_types_pkg::DATA_W-1:0]               prf_data,

    // request to the load pipeline
    input  logic                                            ldu_ready,
    output logic                                            ldu_req_valid,
    output logic [core_types_pkg::DATA_W-1:0]               ldu_req_addr,
    output logic [ldu_pkg::LDU_OP_W-1:0]                    ldu_req_op,
    output logic                                            ldu_req_misaligned,
    output logic [core_types_pkg::LOG_LDU_CQ_ENTRIES-1:0]   ldu_req_cq_index
);
    import core_types_pkg::*;
    import ldu_pkg::*;

    logic [DATA_W-1:0]  base;
    logic [DATA_W-1:0]  addr;
    logic               misaligned;

    always_comb begin
        if (iss.a_is_zero) begin
            base = '0;
        end else if (iss.a_forward) begin
            base = wb.data[iss.a_bank];
        end else begin
            base = prf_data;
        end
    end

    assign addr = base + {{(DATA_W-LDU_IMM_W){iss.imm12[LDU_IMM_W-1]}}, iss.imm12};

    always_comb begin
        case (iss.op[1:0])
            LDU_SIZE_B: misaligned = 1'b0;
            LDU_SIZE_H: misaligned = addr[0];
            LDU_SIZE_W: misaligned = |addr[1:0];
            default:    misaligned = 1'b0;
        endcase
    end

    // ----------------------------------------------------------
    // output register, held while the consumer stalls

    assign iss.pipeline_ready = ~ldu_req_valid | ldu_ready;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ldu_req_valid <= 1'b0;
        end else if (iss.pipeline_ready) begin
            ldu_req_valid <= iss.valid;
        end
    end

    // issue only fires while the register can advance
    always_ff @(posedge CLK) begin
        if (iss.valid) begin
            ldu_req_addr <= addr;
            ldu_req_op <= iss.op;
            ldu_req_misaligned <= misaligned;
            ldu_req_cq_index <= iss.cq_index;
        end
    end

endmodule

`default_nettype wire

// ==== src/ldu_issue_top.sv ====
// load issue subsystem top
// issue queue, banked register file and address stage
`timescale 1ns/1ps
`default_nettype none

module ldu_issue_top #(
    parameter int LDU_IQ_ENTRIES = 4
) (
    input  logic CLK,
    input  logic nRST,

    input  logic                                            enq_valid,
    input  logic [ldu_pkg::LDU_OP_W-1:0]                    enq_op,
    input  logic [ldu_pkg::LDU_IMM_W-1:0]                   enq_imm12,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0]         enq_a_pr,
    input  logic                                            enq_a_ready,
    input  logic                                            enq_a_is_zero,
    input  logic [core_types_pkg::LOG_LDU_CQ_ENTRIES-1:0]   enq_cq_index,
    output logic                                            enq_ready,

    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0]       wb_valid_by_bank,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0]
        [core_types_pkg::LOG_PR_COUNT-core_types_pkg::LOG_PRF_BANK_COUNT-1:0]
        wb_upper_pr_by_bank,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][core_types_pkg::DATA_W-1:0]
        wb_data_by_bank,

    input  logic                                            ldu_ready,
    output logic                                            ldu_req_valid,
    output logic [core_types_pkg::DATA_W-1:0]               ldu_req_addr,
    output logic [ldu_pkg::LDU_OP_W-1:0]                    ldu_req_op,
    output logic                                            ldu_req_misaligned,
    output logic [core_types_pkg::LOG_LDU_CQ_ENTRIES-1:0]   ldu_req_cq_index
);
    import core_types_pkg::*;

    logic                       prf_req_valid;
    logic [LOG_PR_COUNT-1:0]    prf_req_pr;
    logic [DATA_W-1:0]          prf_rd_data;

    wb_bus_if wb ();
    ldu_issue_if iss ();

    assign wb.valid = wb_valid_by_bank;
    assign wb.upper_pr = wb_upper_pr_by_bank;
    assign wb.data = wb_data_by_bank;

    ldu_iq #(.LDU_IQ_ENTRIES(LDU_IQ_ENTRIES)) iq (
        .CLK           (CLK),
        .nRST          (nRST),
        .enq_valid     (enq_valid),
        .enq_op        (enq_op),
        .enq_imm12     (enq_imm12),
        .enq_a_pr      (enq_a_pr),
        .enq_a_ready   (enq_a_ready),
        .enq_a_is_zero (enq_a_is_zero),
        .enq_cq_index  (enq_cq_index),
        .enq_ready     (enq_ready),
        .wb            (wb.listener),
        .iss           (iss.queue),
        .prf_req_valid (prf_req_valid),
        .prf_req_pr    (prf_req_pr)
    );

    prf_banked prf (
        .CLK      (CLK),
        .nRST     (nRST),
        .wb       (wb.listener),
        .rd_valid (prf_req_valid),
        .rd_pr    (prf_req_pr),
        .rd_data  (prf_rd_data)
    );

    ldu_agen agen (
        .CLK                (CLK),
        .nRST               (nRST),
        .iss                (iss.stage),
        .wb                 (wb.listener),
        .prf_data           (prf_rd_data),
        .ldu_ready          (ldu_ready),
        .ldu_req_valid      (ldu_req_valid),
        .ldu_req_addr       (ldu_req_addr),
        .ldu_req_op         (ldu_req_op),
        .ldu_req_misaligned (ldu_req_misaligned),
        .ldu_req_cq_index   (ldu_req_cq_index)
    );

endmodule

`default_nettype wire

// ==== dv/ldu_issue_tb.sv ====
// testbench for the load issue subsystem
// register file model, expected-load FIFO and output monitor
`timescale 1ns/1ps
`default_nettype none

module ldu_issue_tb;
    import core_types_pkg::*;
    import ldu_pkg::*;

    localparam int IQ_DEPTH = 4;
    localparam int TIMEOUT = 200;

    typedef struct packed {
        logic [DATA_W-1:0]             addr;
        logic [LDU_OP_W-1:0]           op;
        logic                          misaligned;
        logic [LOG_LDU_CQ_ENTRIES-1:0] cq;
    } exp_t;

    logic CLK;
    logic nRST;
    logic                                                           enq_valid;
    logic [LDU_OP_W-1:0]                                            enq_op;
    logic [LDU_IMM_W-1:0]                                           enq_imm12;
    logic [LOG_PR_COUNT-1:0]                                        enq_a_pr;
    logic                                                           enq_a_ready;
    logic                                                           enq_a_is_zero;
    logic [LOG_LDU_CQ_ENTRIES-1:0]                                  enq_cq_index;
    logic                                                           enq_ready;
    logic [PRF_BANK_COUNT-1:0]                                      wb_valid_by_bank;
    logic [PRF_BANK_COUNT-1:0][LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] wb_upper_pr_by_bank;
    logic [PRF_BANK_COUNT-1:0][DATA_W-1:0]                          wb_data_by_bank;
    logic                                                           ldu_ready = 1'b1;
    logic                                                           ldu_req_valid;
    logic [DATA_W-1:0]                                              ldu_req_addr;
    logic [LDU_OP_W-1:0]                                            ldu_req_op;
    logic                                                           ldu_req_misaligned;
    logic [LOG_LDU_CQ_ENTRIES-1:0]                                  ldu_req_cq_index;

    // model state
    logic [DATA_W-1:0]              rf_model [PR_COUNT];
    exp_t                           exp_q [$];
    logic [LOG_LDU_CQ_ENTRIES-1:0]  cq_next = '0;
    logic [31:0]                    lfsr_state = 32'h60d3_a3c5;
    logic                           stall_mode = 1'b0;
    logic                           ready_level = 1'b1;
    exp_t                           held = '0;
    logic                           stalled = 1'b0;

    ldu_issue_top #(.LDU_IQ_ENTRIES(IQ_DEPTH)) DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // ------------------------------------------------------------
    // helpers

    function automatic logic next_lfsr_bit();
        logic fb;
        // taps 32, 22, 2, 1
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [LDU_OP_W-1:0] pick_op(input logic [2:0] sel);
        case (sel)
            3'd0: return LDU_LB;
            3'd1: return LDU_LH;
            3'd2: return LDU_LBU;
            3'd3: return LDU_LHU;
            default: return LDU_LW;
        endcase
    endfunction

    // base plus sign-extended immediate
    function automatic logic [DATA_W-1:0] calc_addr(input logic [DATA_W-1:0] base,
                                                    input logic [LDU_IMM_W-1:0] imm);
        return base + {{(DATA_W-LDU_IMM_W){imm[LDU_IMM_W-1]}}, imm};
    endfunction

    // half needs bit 0 clear, word needs bits 1:0 clear
    function automatic logic expect_misaligned(input logic [LDU_OP_W-1:0] op,
                                               input logic [DATA_W-1:0] addr);
        case (op[1:0])
            LDU_SIZE_H: return addr[0];
            LDU_SIZE_W: return addr[1:0] != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        report_fail($sformatf("ERR %s exp=%h got=%h", name, exp, got));
    endtask

    task automatic step();
        @(posedge CLK);
        #1;
    endtask

    task automatic push_expected(input logic [LDU_OP_W-1:0] op, input logic [DATA_W-1:0] addr,
                                 input logic [LOG_LDU_CQ_ENTRIES-1:0] cq);
        exp_t e;
        e.addr = addr;
        e.op = op;
        e.misaligned = expect_misaligned(op, addr);
        e.cq = cq;
        exp_q.push_back(e);
    endtask

    task automatic enqueue_load(input logic [LDU_OP_W-1:0] op, input logic [LDU_IMM_W-1:0] imm,
                                input logic [LOG_PR_COUNT-1:0] pr, input logic rdy,
                                input logic zero);
        int waited;
        waited = 0;
        enq_valid = 1'b1;
        enq_op = op;
        enq_imm12 = imm;
        enq_a_pr = pr;
        enq_a_ready = rdy;
        enq_a_is_zero = zero;
        enq_cq_index = cq_next;
        // taken at the next edge once enq_ready is seen high
        @(negedge CLK);
        while (!enq_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                report_fail("enqueue timed out waiting for enq_ready");
            end
            @(negedge CLK);
        end
        step();
        enq_valid = 1'b0;
        cq_next = cq_next + 1'b1;
    endtask

    task automatic send_ready_load(input logic [LDU_OP_W-1:0] op,
                                   input logic [LDU_IMM_W-1:0] imm,
                                   input logic [LOG_PR_COUNT-1:0] pr, input logic zero);
        push_expected(op, calc_addr(zero ? '0 : rf_model[pr], imm), cq_next);
        enqueue_load(op, imm, pr, 1'b1, zero);
    endtask

    task automatic write_back(input logic [LOG_PR_COUNT-1:0] pr, input logic [DATA_W-1:0] data);
        logic [LOG_PRF_BANK_COUNT-1:0] bank;
        bank = pr[LOG_PRF_BANK_COUNT-1:0];
        wb_valid_by_bank = '0;
        wb_valid_by_bank[bank] = 1'b1;
        wb_upper_pr_by_bank[bank] = pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
        wb_data_by_bank[bank] = data;
        rf_model[pr] = data;
        step();
        wb_valid_by_bank = '0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || ldu_req_valid) begin
            waited++;
            if (waited > TIMEOUT) begin
                report_fail("timed out waiting for the expected loads to come out");
            end
            step();
        end
    endtask

    task automatic compare_load(input exp_t exp, input exp_t got);
        assert (got.addr == exp.addr)
            else report_mismatch("ldu_req_addr", exp.addr, got.addr);
        assert (got.op == exp.op)
            else report_mismatch("ldu_req_op", 32'(exp.op), 32'(got.op));
        assert (got.misaligned == exp.misaligned)
            else report_mismatch("ldu_req_misaligned", 32'(exp.misaligned), 32'(got.misaligned));
        assert (got.cq == exp.cq)
            else report_mismatch("ldu_req_cq_index", 32'(exp.cq), 32'(got.cq));
    endtask

    // ------------------------------------------------------------
    // consumer ready, random while stall_mode is set

    always @(posedge CLK) begin
        #2;
        ldu_ready = stall_mode ? (rand_bits(2) != 32'd0) : ready_level;
    end

    // output monitor, sampled mid-cycle
    always @(negedge CLK) begin
        exp_t got;
        got.addr = ldu_req_addr;
        got.op = ldu_req_op;
        got.misaligned = ldu_req_misaligned;
        got.cq = ldu_req_cq_index;
        if (nRST) begin
            if (ldu_req_valid) begin
                if (stalled) begin
                    compare_load(held, got);
                end else begin
                    assert (exp_q.size() != 0)
                        else report_fail("a load came out that was not expected");
                    compare_load(exp_q.pop_front(), got);
                end
                held = got;
                stalled = !ldu_ready;
            end else begin
                assert (!stalled)
                    else report_fail("held output dropped while the consumer stalled");
                stalled = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus

    initial begin
        logic [LOG_LDU_CQ_ENTRIES-1:0] wait_cq;
        logic [DATA_W-1:0]             value;
        logic [2:0]                    op_sel;
        logic [LDU_IMM_W-1:0]          imm;
        logic [LOG_PR_COUNT-1:0]       pr;
        logic                          zero;

        nRST = 1'b0;
        enq_valid = 1'b0;
        enq_op = '0;
        enq_imm12 = '0;
        enq_a_pr = '0;
        enq_a_ready = 1'b0;
        enq_a_is_zero = 1'b0;
        enq_cq_index = '0;
        wb_valid_by_bank = '0;
        wb_upper_pr_by_bank = '0;
        wb_data_by_bank = '0;
        for (int r = 0; r < PR_COUNT; r++) begin
            rf_model[r] = '0;
        end
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;

        @(negedge CLK);
        assert (!ldu_req_valid) else report_fail("ldu_req_valid high after reset");
        assert (enq_ready) else report_fail("enq_ready low after reset");
        step();

        for (int r = 0; r < PR_COUNT; r++) begin
            value = rand_bits(DATA_W);
            write_back(LOG_PR_COUNT'(r), value);
        end

        // issue one cycle after enqueue, output one cycle after issue
        send_ready_load(LDU_LW, 12'h010, 5'd5, 1'b0);
        @(negedge CLK);
        assert (!ldu_req_valid) else report_fail("load came out without an issue cycle");
        @(negedge CLK);
        assert (ldu_req_valid) else report_fail("load did not come out one cycle after issue");
        step();
        wait_drained();

        // zero base, aligned and misaligned sizes
        send_ready_load(LDU_LH, 12'h001, 5'd3, 1'b1);
        send_ready_load(LDU_LW, 12'h002, 5'd3, 1'b1);
        send_ready_load(LDU_LW, 12'hffe, 5'd3, 1'b1);
        send_ready_load(LDU_LW, 12'h008, 5'd3, 1'b1);
        send_ready_load(LDU_LHU, 12'h006, 5'd3, 1'b1);
        send_ready_load(LDU_LB, 12'h003, 5'd3, 1'b1);
        send_ready_load(LDU_LBU, 12'h7ff, 5'd3, 1'b1);
        wait_drained();

        // random loads with random consumer stalls
        stall_mode = 1'b1;
        for (int k = 0; k < 40; k++) begin
            op_sel = 3'(rand_bits(3));
            imm = LDU_IMM_W'(rand_bits(LDU_IMM_W));
            pr = LOG_PR_COUNT'(rand_bits(LOG_PR_COUNT));
            zero = rand_bits(3) == 32'd0;
            send_ready_load(pick_op(op_sel), imm, pr, zero);
        end
        stall_mode = 1'b0;
        step();
        wait_drained();

        // ------------------------------------------------------------
        // waiting operand woken by a same-cycle forward
        wait_cq = cq_next;
        enqueue_load(LDU_LW, 12'h024, 5'd7, 1'b0, 1'b0);
        send_ready_load(LDU_LB, 12'hff3, 5'd12, 1'b0);
        send_ready_load(LDU_LHU, 12'h00a, 5'd9, 1'b1);
        wait_drained();
        repeat (3) step();
        value = rand_bits(DATA_W);
        push_expected(LDU_LW, calc_addr(value, 12'h024), wait_cq);
        write_back(5'd7, value);
        @(negedge CLK);
        assert (ldu_req_valid) else report_fail("waiting load did not issue on its writeback");
        step();
        wait_drained();

        // waiting operand read from the register file after a stalled wakeup
        ready_level = 1'b0;
        send_ready_load(LDU_LW, 12'h100, 5'd3, 1'b0);
        wait_cq = cq_next;
        enqueue_load(LDU_LH, 12'h803, 5'd20, 1'b0, 1'b0);
        value = rand_bits(DATA_W);
        write_back(5'd20, value);
        repeat (2) step();
        push_expected(LDU_LH, calc_addr(value, 12'h803), wait_cq);
        ready_level = 1'b1;
        wait_drained();

        // fill the queue behind a stalled output
        ready_level = 1'b0;
        for (int k = 0; k <= IQ_DEPTH; k++) begin
            imm = LDU_IMM_W'(rand_bits(LDU_IMM_W));
            send_ready_load(LDU_LW, imm, LOG_PR_COUNT'(k + 10), 1'b0);
        end
        @(negedge CLK);
        assert (!enq_ready) else report_fail("enq_ready stayed high with the queue full");
        repeat (4) step();
        ready_level = 1'b1;
        wait_drained();

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
src/core_types_pkg.sv
src/ldu_pkg.sv
src/wb_bus_if.sv
src/ldu_issue_if.sv
src/pe_lsb.sv
src/ldu_iq.sv
src/prf_banked.sv
src/ldu_agen.sv
src/ldu_issue_top.sv
dv/ldu_issue_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the load issue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module ldu_issue_tb \
    -Mdir obj_dir -o ldu_issue_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/ldu_issue_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0
